/* hdl/spif_config.svh */
// ============================
// build-time sizes and constants of the flash boot loader
// included by the package and by RTL that needs flash constants
// ============================
`ifndef SPIF_CONFIG_SVH
`define SPIF_CONFIG_SVH

// ============================
// memory geometry
// ============================
`define SPIF_WIDTH      18       // data word width
`define SPIF_CODE_SIZE  10       // log2 of code RAM depth
`define SPIF_DATA_SIZE  10       // log2 of data RAM depth

// ============================
// flash
// ============================
`define SPIF_BASEBLOCK  0        // first 64 KB sector of the boot image
`define SPIF_FAST_READ  8'h0B    // read opcode with dummy byte
`define SPIF_RATE_POR   7        // SCLK divisor out of reset

`endif

/* hdl/spif_pkg.sv */
// ============================
// shared types and widths of the boot loader
// imported by every RTL module of the design
// ============================
`default_nettype none

`include "spif_config.svh"

package spif_pkg;

  // ============================
  // widths
  // ============================
  localparam int WORD_W  = `SPIF_WIDTH;          // data RAM word
  localparam int CODE_W  = 16;                   // instruction word
  localparam int CODE_AW = `SPIF_CODE_SIZE;      // code RAM address
  localparam int DATA_AW = `SPIF_DATA_SIZE;      // data RAM address
  localparam int RAM_AW  = (CODE_AW > DATA_AW) ? CODE_AW : DATA_AW;  // spram address

  localparam int HDR_BYTES = 6;                  // opcode, sector, four 00 bytes

  // flash engine format codes
  localparam logic [2:0] FMT_IDLE = 3'd0;        // CS# high
  localparam logic [2:0] FMT_READ = 3'd2;        // continuous read

  // ============================
  // boot command byte
  // ============================
  // tag 11 is end or load, 10 is rate, 0x is word mode
  typedef union packed {
    struct packed {
      logic [1:0] tag;
      logic       fin;                           // end the boot
      logic       rel;                           // release the processor
      logic [1:0] pad;
      logic [1:0] load;                          // bit 1 count, bit 0 two bytes
    } e;
    struct packed {
      logic [1:0] tag;
      logic [1:0] pad;
      logic [3:0] div;                           // new SCLK divisor
    } r;
    struct packed {
      logic [1:0] tag;
      logic [2:0] pad;
      logic       is_data;                       // 1 = data RAM
      logic [1:0] nbm1;                          // bytes per word minus one
    } m;
  } boot_cmd_u;

endpackage

`default_nettype wire

/* hdl/spram.sv */
// ============================
// single-port synchronous RAM with registered read
// one instance each for code and data storage
// ============================
`timescale 1ns/100ps
`default_nettype none

module spram (
  input  wire                         clk,
  input  wire  [spif_pkg::RAM_AW-1:0] i_addr,
  input  wire  [spif_pkg::WORD_W-1:0] i_din,
  input  wire                         i_we,     // write enable
  input  wire                         i_re,     // read enable
  output logic [spif_pkg::WORD_W-1:0] o_dout
);

  import spif_pkg::*;

  logic [WORD_W-1:0] mem [2**RAM_AW];           // storage array

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_din;
    end
    if (i_re) begin
      o_dout <= mem[i_addr];                    // data next cycle
    end
  end

endmodule

`default_nettype wire

/* hdl/boot_sequencer.sv */
// ============================
// flash side of the boot loader
// sends the FAST_READ header and turns each finished transfer into a byte pulse
// ============================
`timescale 1ns/100ps
`default_nettype none

`include "spif_config.svh"

module boot_sequencer (
  input  wire        clk,
  input  wire        arstn,
  input  wire        i_clear_done,   // RAM clear finished
  input  wire        i_f_ready,      // engine ready for a byte
  input  wire  [7:0] i_f_din,        // byte from the last transfer
  input  wire        i_rate_wr,      // rate command strobe
  input  wire  [3:0] i_rate,
  input  wire        i_boot_end,     // end command seen
  output logic       o_f_wr,         // flash strobe
  output logic [7:0] o_f_dout,
  output logic [2:0] o_f_format,
  output logic [3:0] o_f_rate,
  output logic       o_byte_valid,   // stream byte pulse
  output logic [7:0] o_byte,
  output logic       o_booting
);

  import spif_pkg::*;

  logic [2:0] hdr_cnt;               // header transfers sent so far
  logic       hdr_done;

  // ============================
  // strobe and byte delivery
  // ============================
  assign hdr_done     = (hdr_cnt == 3'(HDR_BYTES));
  assign o_f_wr       = o_booting & i_clear_done & i_f_ready;  // ready drops after strobe
  assign o_byte_valid = o_f_wr & hdr_done;   // previous transfer's byte
  assign o_byte       = i_f_din;

  always_comb begin
    case (hdr_cnt)
      3'd0:    o_f_dout = `SPIF_FAST_READ;
      3'd1:    o_f_dout = 8'(`SPIF_BASEBLOCK);
      default: o_f_dout = 8'h00;             // address, dummy and stream fill
    endcase
  end

  // ============================
  // header count, format, rate
  // ============================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      hdr_cnt    <= 3'd0;
      o_f_format <= FMT_IDLE;
      o_f_rate   <= 4'(`SPIF_RATE_POR);
      o_booting  <= 1'b1;
    end else begin
      if (o_f_wr && !hdr_done) begin
        hdr_cnt <= hdr_cnt + 3'd1;
      end
      if (o_f_wr && hdr_cnt == 3'd0) begin
        o_f_format <= FMT_READ;              // CS# low for the whole read
      end
      if (i_rate_wr) begin
        o_f_rate <= i_rate;
      end
      if (i_boot_end) begin
        o_f_format <= FMT_IDLE;              // raise CS#
        o_booting  <= 1'b0;                  // no more strobes
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/boot_interpreter.sv */
// ============================
// decodes the boot byte stream into RAM word writes
// also issues rate updates and the boot end with reset release
// ============================
`timescale 1ns/100ps
`default_nettype none

module boot_interpreter (
  input  wire                         clk,
  input  wire                         arstn,
  input  wire                         i_byte_valid,   // stream byte pulse
  input  wire  [7:0]                  i_byte,
  output logic                        o_word_wr,      // one word ready
  output logic                        o_word_is_data, // 1 = data RAM
  output logic [15:0]                 o_dest,         // word address
  output logic [spif_pkg::WORD_W-1:0] o_word,
  output logic                        o_rate_wr,
  output logic [3:0]                  o_rate,
  output logic                        o_boot_end,
  output logic                        o_p_reset       // processor reset
);

  import spif_pkg::*;

  localparam logic [1:0] M_CMD  = 2'd0;   // command byte expected
  localparam logic [1:0] M_WORD = 2'd1;   // collecting word bytes
  localparam logic [1:0] M_DEST = 2'd2;   // destination load
  localparam logic [1:0] M_CNT  = 2'd3;   // count load

  boot_cmd_u   cmd;
  logic [1:0]  mode;
  logic        hi_pend;                   // high byte of a load comes next
  logic [1:0]  nbm1;                      // bytes per word minus one
  logic [1:0]  byte_left;                 // bytes still missing in this word
  logic [15:0] count;                     // words left minus one
  logic        first_byte;

  assign cmd        = i_byte;
  assign first_byte = (byte_left == nbm1);

  // ============================
  // mode FSM
  // ============================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      mode           <= M_CMD;
      hi_pend        <= 1'b0;
      nbm1           <= 2'd0;
      byte_left      <= 2'd0;
      count          <= 16'd0;
      o_dest         <= 16'd0;
      o_word_wr      <= 1'b0;
      o_word_is_data <= 1'b0;
      o_rate_wr      <= 1'b0;
      o_boot_end     <= 1'b0;
      o_p_reset      <= 1'b1;             // processor held until release
    end else begin
      o_word_wr  <= 1'b0;                 // strobes
      o_rate_wr  <= 1'b0;
      o_boot_end <= 1'b0;
      if (o_word_wr) begin
        o_dest <= o_dest + 16'd1;         // bump after each write
      end
      if (i_byte_valid) begin
        case (mode)
          M_CMD: begin
            case (cmd.e.tag)
              2'b11: begin
                if (cmd.e.fin) begin
                  o_boot_end <= 1'b1;
                  o_p_reset  <= ~cmd.e.rel;
                end else begin
                  mode    <= cmd.e.load[1] ? M_CNT : M_DEST;
                  hi_pend <= cmd.e.load[0];
                end
              end
              2'b10: begin
                o_rate_wr <= 1'b1;        // divisor goes out on o_rate
              end
              default: begin
                mode           <= M_WORD;
                o_word_is_data <= cmd.m.is_data;
                nbm1           <= cmd.m.nbm1;
                byte_left      <= cmd.m.nbm1;
              end
            endcase
          end
          M_WORD: begin
            if (byte_left != 2'd0) begin
              byte_left <= byte_left - 2'd1;
            end else begin
              byte_left <= nbm1;          // rearm for next word
              o_word_wr <= 1'b1;
              if (count != 16'd0) begin
                count <= count - 16'd1;
              end else begin
                mode <= M_CMD;            // run finished
              end
            end
          end
          M_DEST: begin
            if (hi_pend) begin
              o_dest[15:8] <= i_byte;
              hi_pend      <= 1'b0;
            end else begin
              o_dest[7:0] <= i_byte;
              mode        <= M_CMD;
            end
          end
          default: begin
            if (hi_pend) begin
              count[15:8] <= i_byte;
              hi_pend     <= 1'b0;
            end else begin
              count[7:0] <= i_byte;
              mode       <= M_CMD;
            end
          end
        endcase
      end
    end
  end

  // ============================
  // word and rate payload
  // ============================
  always_ff @(posedge clk) begin
    if (i_byte_valid && mode == M_WORD) begin
      if (first_byte) begin
        o_word <= WORD_W'(i_byte);        // fresh word, upper bits zero
      end else begin
        o_word <= {o_word[WORD_W-9:0], i_byte};  // big-endian shift
      end
    end
    if (i_byte_valid && mode == M_CMD && cmd.r.tag == 2'b10) begin
      o_rate <= cmd.r.div;
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_port.sv */
// ============================
// RAM access for boot loader and processor
// clears both RAMs after reset and holds the processor during boot writes
// ============================
`timescale 1ns/100ps
`default_nettype none

module mem_port (
  input  wire                          clk,
  input  wire                          arstn,
  input  wire                          i_word_wr,       // boot word write
  input  wire                          i_word_is_data,
  input  wire  [15:0]                  i_dest,
  input  wire  [spif_pkg::WORD_W-1:0]  i_word,
  input  wire                          i_mem_rd,        // processor data read
  input  wire                          i_mem_wr,        // processor data write
  input  wire  [spif_pkg::DATA_AW-1:0] i_mem_addr,
  input  wire  [spif_pkg::WORD_W-1:0]  i_din,
  input  wire  [spif_pkg::CODE_AW-1:0] i_code_addr,
  output logic                         o_clear_done,
  output logic                         o_p_hold,
  output logic [spif_pkg::WORD_W-1:0]  o_mem_dout,
  output logic [spif_pkg::CODE_W-1:0]  o_insn
);

  import spif_pkg::*;

  logic [RAM_AW-1:0] clr_addr;            // clear sweep address
  logic              clearing;
  logic              boot_code_wr;
  logic              boot_data_wr;
  logic              code_we;
  logic              code_re;
  logic              data_we;
  logic              data_re;
  logic [RAM_AW-1:0] code_a;
  logic [RAM_AW-1:0] data_a;
  logic [WORD_W-1:0] code_d;
  logic [WORD_W-1:0] data_d;
  logic [WORD_W-1:0] code_q;

  // ============================
  // clear sweep
  // ============================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      clr_addr     <= '0;
      o_clear_done <= 1'b0;
    end else if (clearing) begin
      clr_addr <= clr_addr + 1'b1;
      if (&clr_addr) begin
        o_clear_done <= 1'b1;             // last address written
      end
    end
  end

  // ============================
  // access merge
  // ============================
  assign clearing     = ~o_clear_done;
  assign boot_code_wr = i_word_wr & ~i_word_is_data;
  assign boot_data_wr = i_word_wr & i_word_is_data;
  assign o_p_hold     = clearing | i_word_wr;          // processor stalls

  assign code_we = clearing | boot_code_wr;
  assign code_re = ~o_p_hold;                          // fetch only when running
  assign code_a  = clearing     ? clr_addr :
                   boot_code_wr ? RAM_AW'(i_dest[CODE_AW-1:0]) :
                                  RAM_AW'(i_code_addr);
  assign code_d  = clearing ? '0 : i_word;

  assign data_we = clearing | boot_data_wr | (i_mem_wr & ~o_p_hold);
  assign data_re = i_mem_rd & ~o_p_hold;               // held read skipped
  assign data_a  = clearing     ? clr_addr :
                   boot_data_wr ? RAM_AW'(i_dest[DATA_AW-1:0]) :
                                  RAM_AW'(i_mem_addr);
  assign data_d  = clearing     ? '0 :
                   boot_data_wr ? i_word : i_din;

  assign o_insn = code_q[CODE_W-1:0];                  // instruction bits only

  spram code_ram_i (
    .clk    (clk),
    .i_addr (code_a),
    .i_din  (code_d),
    .i_we   (code_we),
    .i_re   (code_re),
    .o_dout (code_q)
  );

  spram data_ram_i (
    .clk    (clk),
    .i_addr (data_a),
    .i_din  (data_d),
    .i_we   (data_we),
    .i_re   (data_re),
    .o_dout (o_mem_dout)
  );

endmodule

`default_nettype wire

/* hdl/spif.sv */
// ============================
// flash boot loader top level
// connects the flash sequencer, stream interpreter and RAM port
// ============================
`timescale 1ns/100ps
`default_nettype none

module spif (
  input  wire                          clk,
  input  wire                          arstn,        // async reset, active low
  // processor side
  input  wire                          i_mem_rd,
  input  wire                          i_mem_wr,
  input  wire  [spif_pkg::DATA_AW-1:0] i_mem_addr,
  input  wire  [spif_pkg::WORD_W-1:0]  i_din,
  input  wire  [spif_pkg::CODE_AW-1:0] i_code_addr,
  output wire  [spif_pkg::WORD_W-1:0]  o_mem_dout,
  output wire  [spif_pkg::CODE_W-1:0]  o_insn,
  output wire                          o_p_hold,
  output wire                          o_p_reset,
  output wire                          o_booting,
  // flash byte engine
  input  wire                          i_f_ready,
  input  wire  [7:0]                   i_f_din,
  output wire                          o_f_wr,
  output wire  [7:0]                   o_f_dout,
  output wire  [2:0]                   o_f_format,
  output wire  [3:0]                   o_f_rate
);

  wire                         clear_done;
  wire                         byte_valid;
  wire [7:0]                   stream_byte;
  wire                         word_wr;
  wire                         word_is_data;
  wire [15:0]                  dest;
  wire [spif_pkg::WORD_W-1:0]  word;
  wire                         rate_wr;
  wire [3:0]                   rate;
  wire                         boot_end;

  boot_sequencer boot_sequencer_i (
    .clk          (clk),
    .arstn        (arstn),
    .i_clear_done (clear_done),
    .i_f_ready    (i_f_ready),
    .i_f_din      (i_f_din),
    .i_rate_wr    (rate_wr),
    .i_rate       (rate),
    .i_boot_end   (boot_end),
    .o_f_wr       (o_f_wr),
    .o_f_dout     (o_f_dout),
    .o_f_format   (o_f_format),
    .o_f_rate     (o_f_rate),
    .o_byte_valid (byte_valid),
    .o_byte       (stream_byte),
    .o_booting    (o_booting)
  );

  boot_interpreter boot_interpreter_i (
    .clk            (clk),
    .arstn          (arstn),
    .i_byte_valid   (byte_valid),
    .i_byte         (stream_byte),
    .o_word_wr      (word_wr),
    .o_word_is_data (word_is_data),
    .o_dest         (dest),
    .o_word         (word),
    .o_rate_wr      (rate_wr),
    .o_rate         (rate),
    .o_boot_end     (boot_end),
    .o_p_reset      (o_p_reset)
  );

  mem_port mem_port_i (
    .clk            (clk),
    .arstn          (arstn),
    .i_word_wr      (word_wr),
    .i_word_is_data (word_is_data),
    .i_dest         (dest),
    .i_word         (word),
    .i_mem_rd       (i_mem_rd),
    .i_mem_wr       (i_mem_wr),
    .i_mem_addr     (i_mem_addr),
    .i_din          (i_din),
    .i_code_addr    (i_code_addr),
    .o_clear_done   (clear_done),
    .o_p_hold       (o_p_hold),
    .o_mem_dout     (o_mem_dout),
    .o_insn         (o_insn)
  );

endmodule

`default_nettype wire

/* verification/flash_model.sv */
// ==============================
// behavioural flash byte engine holding a boot image
// answers strobes after a random delay and checks the header bytes
// ==============================
`timescale 1ns/100ps
`default_nettype none

`include "spif_config.svh"

module flash_model #(
  parameter int IMG_DEPTH = 64
) (
  input  wire        clk,
  input  wire        i_f_wr,                // strobe from the DUT
  input  wire  [7:0] i_f_dout,
  output logic       o_f_ready,
  output logic [7:0] o_f_din,
  output logic [7:0] o_image [IMG_DEPTH],   // image for the reference
  output int         o_len,
  output int         o_strobes,             // strobes seen so far
  output logic       o_hdr_err,             // header byte mismatch
  output logic [7:0] o_hdr_got,
  output logic [7:0] o_hdr_exp
);

  import spif_pkg::*;

  int         seed;
  int         gap;
  int         idx;
  logic [7:0] hdr [HDR_BYTES];

  task automatic put(input logic [7:0] b);
    o_image[o_len] = b;
    o_len = o_len + 1;
  endtask

  task automatic put_random(input int n);   // word payload
    repeat (n) put(8'($random(seed)));
  endtask

  // ==============================
  // boot image
  // ==============================
  initial begin
    seed  = 32'h6b4a3739;
    hdr   = '{`SPIF_FAST_READ, 8'(`SPIF_BASEBLOCK), 8'h00, 8'h00, 8'h00, 8'h00};
    o_len = 0;
    foreach (o_image[i])
      o_image[i] = 8'h00;
    put(8'h83);                             // rate 3
    put(8'hC1);                             // dest, high then low
    put(8'h01);
    put(8'h10);
    put(8'hC3);                             // count, high then low
    put(8'h00);
    put(8'h07);
    put(8'h01);                             // code, 2 bytes per word
    put_random(16);
    put(8'hC0);                             // dest low byte only
    put(8'h20);
    put(8'hC2);                             // count low byte only
    put(8'h04);
    put(8'h04);                             // data, 1 byte per word
    put_random(5);
    put(8'hC1);
    put(8'h03);
    put(8'hF0);
    put(8'hC2);
    put(8'h02);
    put(8'h06);                             // data, 3 bytes per word
    put_random(9);
    put(8'h41);                             // code via tag 01, count now 0
    put_random(2);
    put(8'h07);                             // data, 4 bytes per word
    put_random(4);
    put(8'h8A);                             // rate 10
    put(8'hF0);                             // end and release
    put(8'h01);                             // past the end
  end

  // ==============================
  // byte engine
  // ==============================
  initial begin
    o_f_ready = 1'b1;                       // idle engine
    o_f_din   = 8'h00;
    o_strobes = 0;
    o_hdr_err = 1'b0;
    o_hdr_got = 8'h00;
    o_hdr_exp = 8'h00;
    forever begin
      @(negedge clk);                       // strobe stable mid-cycle
      if (i_f_wr) begin
        idx = o_strobes;
        if (idx < HDR_BYTES && i_f_dout !== hdr[idx]) begin
          o_hdr_got = i_f_dout;
          o_hdr_exp = hdr[idx];
          o_hdr_err = 1'b1;
        end
        o_strobes = o_strobes + 1;
        @(posedge clk);
        #1 o_f_ready = 1'b0;
        gap = 2 + int'($unsigned($random(seed)) % 8);  // 2 to 9 cycles
        repeat (gap) @(posedge clk);
        #1;
        // transfer 5 returns stream byte 0
        o_f_din   = (idx >= 5 && idx - 5 < o_len) ? o_image[idx - 5] : 8'h00;
        o_f_ready = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/spif_tb.sv */
// ==============================
// testbench of the flash boot loader
// boots from the flash model, then checks RAM contents and processor access
// ==============================
`timescale 1ns/100ps
`default_nettype none

`include "spif_config.svh"

module spif_tb;

  import spif_pkg::*;

  localparam int IMG_DEPTH = 64;
  localparam int DRIVE_DLY = 1;             // ns after rising edge
  localparam int BOOT_TMO  = 20000;         // cycles

  logic               clk;
  logic               arstn;
  logic               i_mem_rd;
  logic               i_mem_wr;
  logic [DATA_AW-1:0] i_mem_addr;
  logic [WORD_W-1:0]  i_din;
  logic [CODE_AW-1:0] i_code_addr;
  wire  [WORD_W-1:0]  o_mem_dout;
  wire  [CODE_W-1:0]  o_insn;
  wire                o_p_hold;
  wire                o_p_reset;
  wire                o_booting;
  wire                i_f_ready;
  wire  [7:0]         i_f_din;
  wire                o_f_wr;
  wire  [7:0]         o_f_dout;
  wire  [2:0]         o_f_format;
  wire  [3:0]         o_f_rate;

  logic [7:0]         image [IMG_DEPTH];
  int                 img_len;
  int                 strobes;
  logic               hdr_err;
  logic [7:0]         hdr_got;
  logic [7:0]         hdr_exp;

  // ==============================
  // expected results
  // ==============================
  logic [CODE_W-1:0]  exp_code [2**CODE_AW];
  logic [WORD_W-1:0]  exp_data [2**DATA_AW];
  logic [3:0]         exp_rate;
  logic               exp_release;
  int                 exp_strobes;          // header plus stream bytes up to end
  int                 exp_words;            // words written by the boot
  int                 seed;

  spif dut_i (.*);

  flash_model #(.IMG_DEPTH(IMG_DEPTH)) flash_i (
    .clk       (clk),
    .i_f_wr    (o_f_wr),
    .i_f_dout  (o_f_dout),
    .o_f_ready (i_f_ready),
    .o_f_din   (i_f_din),
    .o_image   (image),
    .o_len     (img_len),
    .o_strobes (strobes),
    .o_hdr_err (hdr_err),
    .o_hdr_got (hdr_got),
    .o_hdr_exp (hdr_exp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                  // 8 ns period
  end

  // walks the boot stream by the command rules
  function automatic void parse_boot_image();
    int                mode;                // 0 cmd, 1 word, 2 dest, 3 count
    int                nbytes;
    int                left;
    logic              hi;
    logic              to_data;
    logic [15:0]       dest;
    logic [15:0]       cnt;
    logic [WORD_W-1:0] w;
    logic [7:0]        b;
    mode = 0;
    nbytes = 1;
    left = 1;
    hi = 1'b0;
    to_data = 1'b0;
    dest = '0;
    cnt = '0;
    w = '0;
    foreach (exp_code[a])
      exp_code[a] = '0;                     // clear pass
    foreach (exp_data[a])
      exp_data[a] = '0;
    exp_rate    = 4'(`SPIF_RATE_POR);
    exp_release = 1'b0;
    exp_strobes = -1;
    exp_words   = 0;
    for (int k = 0; k < img_len && exp_strobes < 0; k++) begin
      b = image[k];
      case (mode)
        0: begin
          if (b[7:6] == 2'b11 && b[5]) begin
            exp_release = b[4];
            exp_strobes = HDR_BYTES + k + 1;
          end else if (b[7:6] == 2'b11) begin
            mode = b[1] ? 3 : 2;
            hi   = b[0];
          end else if (b[7:6] == 2'b10) begin
            exp_rate = b[3:0];
          end else begin
            to_data = b[2];
            nbytes  = int'(b[1:0]) + 1;
            left    = nbytes;
            w       = '0;
            mode    = 1;
          end
        end
        1: begin
          w    = (w << 8) | WORD_W'(b);     // big-endian, oldest bytes drop off
          left = left - 1;
          if (left == 0) begin
            if (to_data)
              exp_data[dest[DATA_AW-1:0]] = w;
            else
              exp_code[dest[CODE_AW-1:0]] = w[CODE_W-1:0];
            exp_words = exp_words + 1;
            dest = dest + 16'd1;
            w    = '0;
            left = nbytes;
            if (cnt == 16'd0)
              mode = 0;
            else
              cnt = cnt - 16'd1;
          end
        end
        2: begin
          if (hi)
            dest[15:8] = b;
          else begin
            dest[7:0] = b;
            mode      = 0;
          end
          hi = 1'b0;
        end
        default: begin
          if (hi)
            cnt[15:8] = b;
          else begin
            cnt[7:0] = b;
            mode     = 0;
          end
          hi = 1'b0;
        end
      endcase
    end
  endfunction

  // ==============================
  // compares and stop
  // ==============================
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic match_code(input int a, input logic [CODE_W-1:0] got,
                            input logic [CODE_W-1:0] exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] t=%0t o_insn code[%0h] got %h exp %h", $time, a, got, exp));
  endtask

  task automatic verify_data(input int a, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] t=%0t o_mem_dout data[%0h] got %h exp %h",
                         $time, a, got, exp));
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] t=%0t %s got %b exp %b", $time, name, got, exp));
  endtask

  task automatic compare_field(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] t=%0t %s got %h exp %h", $time, name, got, exp));
  endtask

  task automatic check_format(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] t=%0t o_f_format got %0d exp %0d", $time, got, exp));
  endtask

  task automatic check_rate(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] t=%0t o_f_rate got %0d exp %0d", $time, got, exp));
  endtask

  task automatic count_equal(input string name, input int got, input int exp);
    if (got != exp)
      stop_run($sformatf("[FAIL] t=%0t %s got %0d exp %0d", $time, name, got, exp));
  endtask

  always @(posedge hdr_err)
    compare_field("o_f_dout header byte", hdr_got, hdr_exp);

  // ==============================
  // waits and processor access
  // ==============================
  task automatic wait_first_strobe();
    int n;
    n = 0;
    while (o_f_wr !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n <= 2**CODE_AW) begin
        expect_flag("o_p_hold", o_p_hold, 1'b1);   // clear in progress
        expect_flag("o_booting", o_booting, 1'b1);
      end
      if (n > 4 * 2**CODE_AW)
        stop_run("no flash strobe came after the RAM clear");
    end
    if (n != 2**CODE_AW + 1)
      stop_run($sformatf("first flash strobe came %0d cycles after reset", n));
  endtask

  task automatic wait_boot_end(output int holds);
    int n;
    n     = 0;
    holds = 0;
    while (o_booting !== 1'b0) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
      if (o_p_hold === 1'b1)
        holds++;                            // one cycle per boot word
      if (n > BOOT_TMO)
        stop_run("boot did not end in time");
    end
  endtask

  task automatic read_code(input int a, output logic [CODE_W-1:0] q);
    @(posedge clk);
    #DRIVE_DLY i_code_addr = CODE_AW'(a);
    @(posedge clk);
    #DRIVE_DLY q = o_insn;                  // one cycle latency
  endtask

  task automatic read_data(input int a, output logic [WORD_W-1:0] q);
    @(posedge clk);
    #DRIVE_DLY;
    i_mem_addr = DATA_AW'(a);
    i_mem_rd   = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    i_mem_rd = 1'b0;
    q        = o_mem_dout;
  endtask

  task automatic write_data(input int a, input logic [WORD_W-1:0] d);
    @(posedge clk);
    #DRIVE_DLY;
    i_mem_addr = DATA_AW'(a);
    i_din      = d;
    i_mem_wr   = 1'b1;
    @(posedge clk);
    #DRIVE_DLY i_mem_wr = 1'b0;
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    logic [CODE_W-1:0] insn;
    logic [WORD_W-1:0] word;
    int                addr;
    int                holds;
    int                wr_addrs [$];
    arstn       = 1'b0;
    i_mem_rd    = 1'b0;
    i_mem_wr    = 1'b0;
    i_mem_addr  = '0;
    i_din       = '0;
    i_code_addr = '0;
    seed        = 32'h6b4a3739;
    repeat (4) @(posedge clk);
    #DRIVE_DLY arstn = 1'b1;
    parse_boot_image();

    check_rate(o_f_rate, 4'(`SPIF_RATE_POR));
    expect_flag("o_p_reset", o_p_reset, 1'b1);
    expect_flag("o_f_wr", o_f_wr, 1'b0);

    wait_first_strobe();
    @(posedge clk);
    #DRIVE_DLY check_format(o_f_format, FMT_READ);

    wait_boot_end(holds);
    count_equal("o_p_hold boot cycles", holds, exp_words);
    check_format(o_f_format, FMT_IDLE);
    check_rate(o_f_rate, exp_rate);
    expect_flag("o_p_reset", o_p_reset, ~exp_release);
    repeat (20) @(posedge clk);             // no strobes after the end
    count_equal("flash strobe count", strobes, exp_strobes);
    expect_flag("o_p_hold", o_p_hold, 1'b0);

    for (addr = 0; addr < 2**CODE_AW; addr++) begin
      read_code(addr, insn);
      match_code(addr, insn, exp_code[addr]);
    end
    for (addr = 0; addr < 2**DATA_AW; addr++) begin
      read_data(addr, word);
      verify_data(addr, word, exp_data[addr]);   // unwritten ones read zero
    end

    // processor round trip to the data RAM
    repeat (16) begin
      addr = int'($unsigned($random(seed)) % (2**DATA_AW));
      word = WORD_W'($random(seed));
      write_data(addr, word);
      exp_data[addr] = word;
      wr_addrs.push_back(addr);
    end
    foreach (wr_addrs[i]) begin
      read_data(wr_addrs[i], word);
      verify_data(wr_addrs[i], word, exp_data[wr_addrs[i]]);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* spif.f */
+incdir+hdl
hdl/spif_pkg.sv
hdl/spram.sv
hdl/boot_sequencer.sv
hdl/boot_interpreter.sv
hdl/mem_port.sv
hdl/spif.sv
verification/flash_model.sv
verification/spif_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module spif_tb -f spif.f -o spif_sim
./obj_dir/spif_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "RESULT: PASS" sim.log
